//--- all.f
logic/rv_core_pkg.sv
logic/exec_req_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/rv_core.sv
tb/tb_clock.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

//--- logic/decode_stage.sv
module decode_stage import rv_core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fd_valid_i,
    input  inst_u                fd_inst_i,
    output logic [REG_IDX_W-1:0] rs1_o,
    output logic [REG_IDX_W-1:0] rs2_o,
    input  logic [XLEN-1:0]      rdata1_i,
    input  logic [XLEN-1:0]      rdata2_i,
    input  logic                 ex_fwd_en_i,
    input  logic [REG_IDX_W-1:0] ex_fwd_addr_i,
    input  logic [XLEN-1:0]      ex_fwd_data_i,
    input  logic                 wb_en_i,
    input  logic [REG_IDX_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]      wb_data_i,
    exec_req_if.src              req
);

    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      imm;
    logic                 use_imm;
    logic                 known;
    logic [ALU_OP_W-1:0]  alu_op;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;

    function automatic logic [ALU_OP_W-1:0] f3_to_alu(input logic [2:0] f3);
        case (f3)
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic logic f3_kept(input logic [2:0] f3);
        return f3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND};
    endfunction

    // execute result wins over writeback, then the register file
    function automatic logic [XLEN-1:0] fwd_operand(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      rf_data
    );
        if (ex_fwd_en_i && ex_fwd_addr_i == idx) begin
            return ex_fwd_data_i;
        end else if (wb_en_i && wb_addr_i == idx) begin
            return wb_data_i;
        end else begin
            return rf_data;
        end
    endfunction

    // ********************************************************************
    // field extraction and alu code
    // ********************************************************************
    always_comb begin
        rs1_idx = '0;
        rs2_idx = '0;
        rd_idx  = '0;
        imm     = '0;
        use_imm = 1'b0;
        known   = 1'b0;
        alu_op  = ALU_ADD;
        case (fd_inst_i.r_fmt.opcode)
            OPC_LUI: begin
                rd_idx  = fd_inst_i.u_fmt.rd;
                imm     = {{(XLEN-ILEN){fd_inst_i.u_fmt.imm20[19]}},
                           fd_inst_i.u_fmt.imm20, 12'b0};
                use_imm = 1'b1;
                alu_op  = ALU_PASS;
                known   = 1'b1;
            end
            OPC_OP_IMM: begin
                rs1_idx = fd_inst_i.i_fmt.rs1;
                rd_idx  = fd_inst_i.i_fmt.rd;
                imm     = {{(XLEN-12){fd_inst_i.i_fmt.imm12[11]}}, fd_inst_i.i_fmt.imm12};
                use_imm = 1'b1;
                alu_op  = f3_to_alu(fd_inst_i.i_fmt.funct3);
                known   = f3_kept(fd_inst_i.i_fmt.funct3);
            end
            OPC_OP: begin
                rs1_idx = fd_inst_i.r_fmt.rs1;
                rs2_idx = fd_inst_i.r_fmt.rs2;
                rd_idx  = fd_inst_i.r_fmt.rd;
                alu_op  = f3_to_alu(fd_inst_i.r_fmt.funct3);
                known   = f3_kept(fd_inst_i.r_fmt.funct3) && fd_inst_i.r_fmt.funct7 == '0;
                // sub is add with funct7 set
                if (fd_inst_i.r_fmt.funct3 == F3_ADD && fd_inst_i.r_fmt.funct7 == F7_SUB) begin
                    alu_op = ALU_SUB;
                    known  = 1'b1;
                end
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign rs1_o = rs1_idx;
    assign rs2_o = rs2_idx;

    // operand select through the bypass
    always_comb begin
        op1 = fwd_operand(rs1_idx, rdata1_i);
        op2 = use_imm ? imm : fwd_operand(rs2_idx, rdata2_i);
    end

    // decode/execute register, x0 writes dropped here
    always_ff @(posedge clk) begin
        if (rst_n) begin
            req.valid  <= 1'b0;
            req.reg_we <= 1'b0;
        end else begin
            req.valid  <= fd_valid_i;
            req.reg_we <= fd_valid_i && known && rd_idx != '0;
        end
    end

    always_ff @(posedge clk) begin
        req.alu_op <= alu_op;
        req.op1    <= op1;
        req.op2    <= op2;
        req.rd     <= rd_idx;
    end

endmodule

//--- logic/exec_req_if.sv
interface exec_req_if import rv_core_pkg::*; ();

    // one decoded operation per cycle, no handshake
    logic                 valid;
    logic [ALU_OP_W-1:0]  alu_op;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [REG_IDX_W-1:0] rd;
    logic                 reg_we;

    // decode side
    modport src (
        output valid, alu_op, op1, op2, rd, reg_we
    );

    // execute side
    modport dst (
        input valid, alu_op, op1, op2, rd, reg_we
    );

endinterface

//--- logic/execute_stage.sv
module execute_stage import rv_core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    exec_req_if.dst              req,
    output logic                 ex_fwd_en_o,
    output logic [REG_IDX_W-1:0] ex_fwd_addr_o,
    output logic [XLEN-1:0]      ex_fwd_data_o,
    output logic                 wb_en_o,
    output logic [REG_IDX_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]      wb_data_o
);

    logic [XLEN-1:0] alu_res;

    // ********************************************************************
    // alu
    // ********************************************************************
    always_comb begin
        case (req.alu_op)
            ALU_ADD:  alu_res = req.op1 + req.op2;
            ALU_SUB:  alu_res = req.op1 - req.op2;
            // signed compare, result 0 or 1
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(req.op1) < $signed(req.op2)};
            ALU_XOR:  alu_res = req.op1 ^ req.op2;
            ALU_OR:   alu_res = req.op1 | req.op2;
            ALU_AND:  alu_res = req.op1 & req.op2;
            ALU_PASS: alu_res = req.op2;
            default:  alu_res = '0;
        endcase
    end

    // in-flight result back to decode
    assign ex_fwd_en_o   = req.valid && req.reg_we;
    assign ex_fwd_addr_o = req.rd;
    assign ex_fwd_data_o = alu_res;

    // execute/writeback register
    always_ff @(posedge clk) begin
        if (rst_n) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= ex_fwd_en_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= req.rd;
        wb_data_o <= alu_res;
    end

endmodule

//--- logic/fetch_stage.sv
module fetch_stage import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [ILEN-1:0] inst_i,
    output logic [XLEN-1:0] pc_o,
    output logic            fd_valid_o,
    output logic [XLEN-1:0] fd_pc_o,
    output inst_u           fd_inst_o
);

    logic [XLEN-1:0] pc;

    // no branches, pc only steps forward
    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc         <= PC_RESET;
            fd_valid_o <= 1'b0;
        end else begin
            pc         <= pc + PC_STEP;
            fd_valid_o <= 1'b1;
        end
    end

    // ********************************************************************
    // fetch/decode register
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            fd_pc_o   <= PC_RESET;
            fd_inst_o <= NOP_WORD;
        end else begin
            // memory answers in the same cycle
            fd_pc_o   <= pc;
            fd_inst_o <= inst_i;
        end
    end

    assign pc_o = pc;

endmodule

//--- logic/reg_file.sv
module reg_file import rv_core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] raddr1_i,
    input  logic [REG_IDX_W-1:0] raddr2_i,
    output logic [XLEN-1:0]      rdata1_o,
    output logic [XLEN-1:0]      rdata2_o,
    input  logic                 we_i,
    input  logic [REG_IDX_W-1:0] waddr_i,
    input  logic [XLEN-1:0]      wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // rd == 0 is already filtered in decode
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, x0 hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- logic/rv_core.sv
module rv_core import rv_core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [XLEN-1:0]      inst_addr_o,
    input  logic [ILEN-1:0]      inst_i,
    output logic                 wb_en_o,
    output logic [REG_IDX_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]      wb_data_o
);

    // fetch to decode
    logic            fd_valid;
    logic [XLEN-1:0] fd_pc;
    inst_u           fd_inst;

    // register read
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [XLEN-1:0]      rdata1;
    logic [XLEN-1:0]      rdata2;

    // execute bypass
    logic                 ex_fwd_en;
    logic [REG_IDX_W-1:0] ex_fwd_addr;
    logic [XLEN-1:0]      ex_fwd_data;

    exec_req_if ex_req ();

    // ********************************************************************
    // stage chain
    // ********************************************************************
    fetch_stage u_fetch (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .inst_i     (inst_i     ),
        .pc_o       (inst_addr_o),
        .fd_valid_o (fd_valid   ),
        .fd_pc_o    (fd_pc      ),
        .fd_inst_o  (fd_inst    )
    );

    decode_stage u_decode (
        .clk           (clk        ),
        .rst_n         (rst_n      ),
        .fd_valid_i    (fd_valid   ),
        .fd_inst_i     (fd_inst    ),
        .rs1_o         (rs1        ),
        .rs2_o         (rs2        ),
        .rdata1_i      (rdata1     ),
        .rdata2_i      (rdata2     ),
        .ex_fwd_en_i   (ex_fwd_en  ),
        .ex_fwd_addr_i (ex_fwd_addr),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_en_i       (wb_en_o    ),
        .wb_addr_i     (wb_addr_o  ),
        .wb_data_i     (wb_data_o  ),
        .req           (ex_req     )
    );

    // writeback triple is also the commit trace
    execute_stage u_execute (
        .clk           (clk        ),
        .rst_n         (rst_n      ),
        .req           (ex_req     ),
        .ex_fwd_en_o   (ex_fwd_en  ),
        .ex_fwd_addr_o (ex_fwd_addr),
        .ex_fwd_data_o (ex_fwd_data),
        .wb_en_o       (wb_en_o    ),
        .wb_addr_o     (wb_addr_o  ),
        .wb_data_o     (wb_data_o  )
    );

    reg_file u_regs (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .raddr1_i (rs1      ),
        .raddr2_i (rs2      ),
        .rdata1_o (rdata1   ),
        .rdata2_o (rdata2   ),
        .we_i     (wb_en_o  ),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

endmodule

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

    // ********************************************************************
    // widths and reset values
    // ********************************************************************
    localparam int XLEN      = 64;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    localparam logic [XLEN-1:0] PC_RESET = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

    // ********************************************************************
    // instruction encodings
    // ********************************************************************
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // shared by the immediate and register groups
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [ILEN-1:0] NOP_WORD = 32'h0000_0013;

    // ********************************************************************
    // alu codes
    // ********************************************************************
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd5;
    // result is operand 2, used by lui
    localparam logic [ALU_OP_W-1:0] ALU_PASS = 3'd6;

    // one instruction word, three views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } inst_u;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/rv_core_asserts.sv
module rv_core_asserts import rv_core_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic [XLEN-1:0]      inst_addr_i,
    input logic                 wb_en_i,
    input logic [REG_IDX_W-1:0] wb_addr_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // x0 is never a commit target
    no_x0_commit: assert property (@(posedge clk) wb_en_i |-> wb_addr_i != '0)
        else $error("commit with wb_addr_o equal to 0");

    // straight-line fetch outside reset
    pc_steps: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> inst_addr_i == $past(inst_addr_i) + PC_STEP)
        else $error("inst_addr_o did not advance by one step");

    quiet_after_reset: assert property (@(posedge clk) $fell(rst_n) |=> !wb_en_i)
        else $error("wb_en_o high in the first cycle after reset");

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .inst_addr_i (inst_addr_o),
    .wb_en_i     (wb_en_o    ),
    .wb_addr_i   (wb_addr_o  )
);

//--- tb/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 rst_n;
    logic [XLEN-1:0]      inst_addr;
    logic [ILEN-1:0]      inst_data;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_addr;
    logic [XLEN-1:0]      wb_data;

    // program image, word index counted from PC_RESET
    logic [ILEN-1:0] imem [64];
    int              prog_len;
    logic [XLEN-1:0] mem_idx;

    logic [REG_IDX_W-1:0] exp_rd [$];
    logic [XLEN-1:0]      exp_val [$];
    logic [REG_IDX_W-1:0] got_rd [$];
    logic [XLEN-1:0]      got_val [$];

    logic [31:0] rng_state;
    string       test_name;
    int          test_errs;
    int          n_pass;
    int          n_fail;

    tb_clock u_clock (.clk_o(clk));

    rv_core u_rv_core (
        .clk         (clk      ),
        .rst_n       (rst_n    ),
        .inst_addr_o (inst_addr),
        .inst_i      (inst_data),
        .wb_en_o     (wb_en    ),
        .wb_addr_o   (wb_addr  ),
        .wb_data_o   (wb_data  )
    );

    // instruction memory, nop beyond the program
    always_comb begin
        mem_idx = (inst_addr - PC_RESET) >> 2;
        if (mem_idx < XLEN'(prog_len)) begin
            inst_data = imem[mem_idx[5:0]];
        end else begin
            inst_data = NOP_WORD;
        end
    end

    // commit monitor
    always @(negedge clk) begin
        if (!rst_n && wb_en) begin
            got_rd.push_back(wb_addr);
            got_val.push_back(wb_data);
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [REG_IDX_W-1:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return REG_IDX_W'(r % 32'd7) + 5'd1;
    endfunction

    function automatic logic [2:0] pick_f3();
        logic [31:0] r;
        r = next_rand();
        case (r % 32'd5)
            32'd0:   return F3_ADD;
            32'd1:   return F3_SLT;
            32'd2:   return F3_XOR;
            32'd3:   return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    // ********************************************************************
    // program assembly
    // ********************************************************************
    task automatic put_word(input inst_u w);
        imem[prog_len[5:0]] = w;
        prog_len++;
    endtask

    task automatic put_r(input logic [6:0] f7, input logic [2:0] f3,
                         input logic [REG_IDX_W-1:0] rd, input logic [REG_IDX_W-1:0] rs1,
                         input logic [REG_IDX_W-1:0] rs2);
        inst_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = OPC_OP;
        put_word(w);
    endtask

    task automatic put_i(input logic [2:0] f3, input logic [REG_IDX_W-1:0] rd,
                         input logic [REG_IDX_W-1:0] rs1, input logic [11:0] imm);
        inst_u w;
        w.i_fmt.imm12  = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = OPC_OP_IMM;
        put_word(w);
    endtask

    task automatic put_u(input logic [REG_IDX_W-1:0] rd, input logic [19:0] imm);
        inst_u w;
        w.u_fmt.imm20  = imm;
        w.u_fmt.rd     = rd;
        w.u_fmt.opcode = OPC_LUI;
        put_word(w);
    endtask

    // reference interpreter, builds the expected commit list
    task automatic interpret();
        logic [XLEN-1:0] regs [NUM_REGS];
        inst_u           w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] val;
        logic [2:0]      f3;
        logic            ok;
        logic            sub;
        exp_rd.delete();
        exp_val.delete();
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            w   = imem[i[5:0]];
            a   = regs[w.r_fmt.rs1];
            b   = regs[w.r_fmt.rs2];
            f3  = w.r_fmt.funct3;
            val = '0;
            ok  = 1'b0;
            sub = 1'b0;
            if (w.u_fmt.opcode == OPC_LUI) begin
                val = {{32{w.u_fmt.imm20[19]}}, w.u_fmt.imm20, 12'h000};
                ok  = 1'b1;
            end else if (w.u_fmt.opcode == OPC_OP_IMM || w.u_fmt.opcode == OPC_OP) begin
                if (w.u_fmt.opcode == OPC_OP_IMM) begin
                    b  = {{52{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
                    ok = 1'b1;
                end else begin
                    sub = (w.r_fmt.funct7 == F7_SUB) && (f3 == F3_ADD);
                    ok  = (w.r_fmt.funct7 == 7'd0) || sub;
                end
                case (f3)
                    F3_ADD:  val = sub ? a - b : a + b;
                    F3_SLT:  val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    F3_XOR:  val = a ^ b;
                    F3_OR:   val = a | b;
                    F3_AND:  val = a & b;
                    default: ok = 1'b0;
                endcase
            end
            if (ok && w.u_fmt.rd != '0) begin
                regs[w.u_fmt.rd] = val;
                exp_rd.push_back(w.u_fmt.rd);
                exp_val.push_back(val);
            end
        end
    endtask

    // ********************************************************************
    // checks and test bookkeeping
    // ********************************************************************
    task automatic check_word(input string what, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg_idx(input string what, input logic [REG_IDX_W-1:0] exp,
                                 input logic [REG_IDX_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: %s expected x%0d actual x%0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok", test_name);
        end else begin
            n_fail++;
            $display("test %s: %0d error(s)", test_name, test_errs);
        end
    endtask

    // program is loaded while the core sits in reset
    task automatic enter_reset();
        @(posedge clk);
        #2;
        rst_n    = 1'b1;
        prog_len = 0;
    endtask

    task automatic release_reset();
        repeat (8) @(posedge clk);
        #2;
        got_rd.delete();
        got_val.delete();
        rst_n = 1'b0;
    endtask

    task automatic wait_commits(input int n);
        int cyc;
        cyc = 0;
        while (got_rd.size() < n && cyc < 50) begin
            @(negedge clk);
            #1;
            cyc++;
        end
        if (got_rd.size() < n) begin
            report_problem($sformatf("timed out with %0d of %0d commits", got_rd.size(), n));
        end
    endtask

    // run past the last word so stray commits show up
    task automatic wait_drain();
        int              cyc;
        logic [XLEN-1:0] last;
        cyc  = 0;
        last = PC_RESET + XLEN'((prog_len + 4) * 4);
        while (inst_addr < last && cyc < 50) begin
            @(negedge clk);
            #1;
            cyc++;
        end
        if (inst_addr < last) begin
            report_problem("timed out before the program drained");
        end
    endtask

    task automatic run_and_compare();
        int n;
        interpret();
        release_reset();
        wait_commits(exp_rd.size());
        wait_drain();
        if (got_rd.size() != exp_rd.size()) begin
            $display("** Error %s: commit count expected %0d actual %0d",
                     test_name, exp_rd.size(), got_rd.size());
            test_errs++;
        end
        n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
        for (int i = 0; i < n; i++) begin
            check_reg_idx($sformatf("commit %0d rd", i), exp_rd[i], got_rd[i]);
            check_word($sformatf("commit %0d value", i), exp_val[i], got_val[i]);
        end
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************
    task automatic test_reset_fetch();
        logic [XLEN-1:0] exp_addr;
        start_test("reset_fetch");
        enter_reset();
        put_i(F3_ADD, 5'd1, 5'd0, 12'h05a);
        interpret();
        release_reset();
        exp_addr = PC_RESET;
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            check_word("inst_addr_o", exp_addr, inst_addr);
            if (k != 3 && wb_en) begin
                report_problem($sformatf("unexpected commit in cycle %0d", k));
            end
            if (k == 3 && !wb_en) begin
                report_problem("no commit 3 cycles after the first address");
            end else if (k == 3) begin
                check_reg_idx("wb_addr_o", exp_rd[0], wb_addr);
                check_word("wb_data_o", exp_val[0], wb_data);
            end
            exp_addr = exp_addr + PC_STEP;
        end
        finish_test();
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        start_test("immediates");
        enter_reset();
        r = next_rand();
        put_u(5'd5, {1'b1, r[18:0]});
        r = next_rand();
        // negative imm12 for sign extension
        put_i(F3_ADD, 5'd5, 5'd5, {1'b1, r[10:0]});
        put_i(F3_XOR, 5'd5, 5'd5, r[22:11]);
        r = next_rand();
        put_i(F3_OR, 5'd5, 5'd5, {1'b1, r[10:0]});
        put_i(F3_AND, 5'd5, 5'd5, r[23:12]);
        put_i(F3_SLT, 5'd5, 5'd5, {1'b1, r[30:20]});
        run_and_compare();
        finish_test();
    endtask

    task automatic test_dependencies();
        logic [31:0] r;
        start_test("dependencies");
        enter_reset();
        r = next_rand();
        put_i(F3_ADD, 5'd1, 5'd0, r[11:0]);
        put_i(F3_ADD, 5'd2, 5'd0, r[23:12]);
        put_r(7'd0, F3_ADD, 5'd3, 5'd1, 5'd2);
        put_r(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1);
        // previous result and the one two before
        put_r(7'd0, F3_XOR, 5'd5, 5'd4, 5'd3);
        put_r(7'd0, F3_OR, 5'd6, 5'd5, 5'd4);
        put_r(7'd0, F3_AND, 5'd7, 5'd6, 5'd5);
        put_r(7'd0, F3_SLT, 5'd1, 5'd7, 5'd5);
        put_r(7'd0, F3_ADD, 5'd2, 5'd1, 5'd6);
        run_and_compare();
        finish_test();
    endtask

    task automatic test_x0_rule();
        logic [31:0] r;
        start_test("x0_rule");
        enter_reset();
        r = next_rand();
        put_i(F3_ADD, 5'd1, 5'd0, r[11:0]);
        put_i(F3_ADD, 5'd0, 5'd1, 12'h007);
        put_r(7'd0, F3_ADD, 5'd2, 5'd0, 5'd1);
        put_r(7'd0, F3_OR, 5'd0, 5'd1, 5'd1);
        put_r(7'd0, F3_XOR, 5'd3, 5'd0, 5'd1);
        put_u(5'd0, r[31:12]);
        put_i(F3_OR, 5'd4, 5'd0, 12'h0f0);
        run_and_compare();
        finish_test();
    endtask

    task automatic test_unknown_opcodes();
        logic [31:0] r;
        start_test("unknown_opcodes");
        enter_reset();
        r = next_rand();
        put_i(F3_ADD, 5'd1, 5'd0, r[11:0]);
        // opcode 7f with rd x1, then a load into x2
        put_word(32'h0000_80ff);
        put_word(32'h0000_b103);
        // kept opcode, unlisted funct3
        put_i(3'b001, 5'd2, 5'd1, 12'h003);
        put_i(F3_ADD, 5'd2, 5'd1, r[23:12]);
        put_r(7'd0, F3_ADD, 5'd3, 5'd2, 5'd1);
        run_and_compare();
        finish_test();
    endtask

    task automatic test_random_program();
        logic [31:0] r;
        logic [2:0]  f3;
        start_test("random_program");
        enter_reset();
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            case (r % 32'd3)
                32'd0:   put_u(pick_reg(), r[31:12]);
                32'd1:   put_i(pick_f3(), pick_reg(), pick_reg(), r[31:20]);
                default: begin
                    f3 = pick_f3();
                    put_r((f3 == F3_ADD && r[8]) ? F7_SUB : 7'd0, f3,
                          pick_reg(), pick_reg(), pick_reg());
                end
            endcase
        end
        run_and_compare();
        finish_test();
    endtask

    initial begin
        rst_n     = 1'b1;
        prog_len  = 0;
        rng_state = 32'd1639;
        n_pass    = 0;
        n_fail    = 0;
        test_reset_fetch();
        test_immediates();
        test_dependencies();
        test_x0_rule();
        test_unknown_opcodes();
        test_random_program();
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

endmodule
